// File: filelist.f
+incdir+hw
hw/irq_pkg.sv
hw/sync_fifo.sv
hw/irq_source.sv
hw/irq_dispatcher.sv
hw/irq_controller.sv
testbench/tb_irq_controller.sv

// File: hw/irq_controller.sv
`timescale 1ns/1ns
`include "irq_settings.svh"

module irq_controller (
    input  logic               CLOCK_50,
    input  logic               rst_n_i,
    input  irq_pkg::scancode_t scancode_i,
    input  logic               scancode_valid_i,
    input  logic               sw_irq_i,
    input  irq_pkg::irq_type_t sw_irq_type_i,
    input  irq_pkg::word_t     sw_irq_value_i,
    input  logic               vector_we_i,
    input  irq_pkg::irq_type_t vector_index_i,
    input  irq_pkg::word_t     vector_addr_i,
    input  logic               iret_i,
    input  irq_pkg::word_t     ip_i,
    input  irq_pkg::word_t     code_base_i,
    input  irq_pkg::word_t     program_end_i,
    output logic               overflow_o,
    output logic               dispatch_o,
    output irq_pkg::word_t     isr_addr_o,
    output irq_pkg::word_t     return_addr_o,
    output irq_pkg::irq_type_t irq_type_o,
    output irq_pkg::word_t     irq_value_o,
    output logic               in_service_o
);

    import irq_pkg::*;

    logic       queue_push;
    irq_entry_t queue_entry;
    logic       queue_full;
    logic       queue_pop;
    irq_entry_t queue_head;
    logic       queue_empty;

    // Key and software requests enter the queue here.
    irq_source u_irq_source (
        .CLOCK_50         (CLOCK_50),
        .rst_n_i          (rst_n_i),
        .scancode_i       (scancode_i),
        .scancode_valid_i (scancode_valid_i),
        .sw_irq_i         (sw_irq_i),
        .sw_irq_type_i    (sw_irq_type_i),
        .sw_irq_value_i   (sw_irq_value_i),
        .queue_full_i     (queue_full),
        .queue_push_o     (queue_push),
        .queue_entry_o    (queue_entry),
        .overflow_o       (overflow_o)
    );

    // Shared interrupt queue.
    sync_fifo #(
        .item_t (irq_entry_t),
        .DEPTH  (`IRQ_QUEUE_DEPTH)
    ) u_irq_queue (
        .CLOCK_50 (CLOCK_50),
        .rst_n_i  (rst_n_i),
        .push_i   (queue_push),
        .item_i   (queue_entry),
        .pop_i    (queue_pop),
        .item_o   (queue_head),
        .empty_o  (queue_empty),
        .full_o   (queue_full)
    );

    irq_dispatcher u_irq_dispatcher (
        .CLOCK_50       (CLOCK_50),
        .rst_n_i        (rst_n_i),
        .queue_empty_i  (queue_empty),
        .queue_head_i   (queue_head),
        .queue_pop_o    (queue_pop),
        .vector_we_i    (vector_we_i),
        .vector_index_i (vector_index_i),
        .vector_addr_i  (vector_addr_i),
        .ip_i           (ip_i),
        .code_base_i    (code_base_i),
        .program_end_i  (program_end_i),
        .iret_i         (iret_i),
        .dispatch_o     (dispatch_o),
        .isr_addr_o     (isr_addr_o),
        .return_addr_o  (return_addr_o),
        .irq_type_o     (irq_type_o),
        .irq_value_o    (irq_value_o),
        .in_service_o   (in_service_o)
    );

endmodule

// File: hw/irq_dispatcher.sv
`timescale 1ns/1ns
`include "irq_settings.svh"

module irq_dispatcher (
    input  logic                CLOCK_50,
    input  logic                rst_n_i,
    input  logic                queue_empty_i,
    input  irq_pkg::irq_entry_t queue_head_i,
    output logic                queue_pop_o,
    input  logic                vector_we_i,
    input  irq_pkg::irq_type_t  vector_index_i,
    input  irq_pkg::word_t      vector_addr_i,
    input  irq_pkg::word_t      ip_i,
    input  irq_pkg::word_t      code_base_i,
    input  irq_pkg::word_t      program_end_i,
    input  logic                iret_i,
    output logic                dispatch_o,
    output irq_pkg::word_t      isr_addr_o,
    output irq_pkg::word_t      return_addr_o,
    output irq_pkg::irq_type_t  irq_type_o,
    output irq_pkg::word_t      irq_value_o,
    output logic                in_service_o
);

    import irq_pkg::*;

    // Vector entries are offsets from the start of the code section.
    word_t     vector_table [`IRQ_NUM_VECTORS];
    irq_type_t head_type;
    word_t     return_sum;

    assign head_type = queue_head_i.irq_type;

    // Address of the instruction after the current one.
    assign return_sum = ip_i + word_t'(`IRQ_INSTR_BYTES);

    // Only one routine runs at a time; the rest stay queued.
    assign queue_pop_o = !in_service_o && !queue_empty_i;

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `IRQ_NUM_VECTORS; i++)
            begin
                vector_table[i] <= '0;
            end
        end
        else if (vector_we_i)
        begin
            vector_table[vector_index_i] <= vector_addr_i;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            dispatch_o   <= 1'b0;
            in_service_o <= 1'b0;
        end
        else
        begin
            dispatch_o <= queue_pop_o;
            // A pop only happens while idle, so it cannot collide with a return.
            if (queue_pop_o)
                in_service_o <= 1'b1;
            else if (iret_i)
                in_service_o <= 1'b0;
        end
    end

    // Service context is captured on the pop edge, alongside the dispatch pulse.
    always_ff @(posedge CLOCK_50)
    begin
        if (queue_pop_o)
        begin
            isr_addr_o <= code_base_i + vector_table[head_type];
            // Near the end of the program, resume at the current instruction.
            if (return_sum >= program_end_i)
                return_addr_o <= ip_i;
            else
                return_addr_o <= return_sum;
            irq_type_o  <= head_type;
            irq_value_o <= queue_head_i.value;
        end
    end

endmodule

// File: hw/irq_pkg.sv
`include "irq_settings.svh"

package irq_pkg;

    // Address or data word of the CPU.
    typedef logic [`IRQ_WORD_BITS-1:0] word_t;

    // Raw keyboard scancode as delivered by the keyboard receiver.
    typedef logic [7:0] scancode_t;

    // Interrupt type number, also the vector table index.
    typedef logic [$clog2(`IRQ_NUM_VECTORS)-1:0] irq_type_t;

    // One pending interrupt.
    // The value is handed to the service routine as its argument.
    typedef struct packed {
        irq_type_t irq_type;
        word_t     value;
    } irq_entry_t;

endpackage

// File: hw/irq_settings.svh
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Machine word width, used for addresses and interrupt values.
`define IRQ_WORD_BITS 32

// Number of interrupt types, one vector table entry each.
`define IRQ_NUM_VECTORS 8

// Scancodes that can wait before they become key interrupts.
`define IRQ_SCANCODE_DEPTH 5

// Pending interrupts held in the shared interrupt queue.
`define IRQ_QUEUE_DEPTH 10

// One instruction is an opcode byte plus two 4-byte operands.
`define IRQ_INSTR_BYTES 9

// Interrupt type raised for every keyboard scancode.
`define IRQ_TYPE_KEY 0

`endif

// File: hw/irq_source.sv
`timescale 1ns/1ns
`include "irq_settings.svh"

module irq_source (
    input  logic                CLOCK_50,
    input  logic                rst_n_i,
    input  irq_pkg::scancode_t  scancode_i,
    input  logic                scancode_valid_i,
    input  logic                sw_irq_i,
    input  irq_pkg::irq_type_t  sw_irq_type_i,
    input  irq_pkg::word_t      sw_irq_value_i,
    input  logic                queue_full_i,
    output logic                queue_push_o,
    output irq_pkg::irq_entry_t queue_entry_o,
    output logic                overflow_o
);

    import irq_pkg::*;

    scancode_t  sc_head;
    logic       sc_empty;
    logic       sc_full;
    logic       sc_pop;
    logic       queue_busy;
    logic       sw_accept;
    logic       sw_drop;
    logic       key_drop;
    irq_entry_t next_entry;

    // Scancodes wait here until the interrupt queue has room.
    sync_fifo #(
        .item_t (scancode_t),
        .DEPTH  (`IRQ_SCANCODE_DEPTH)
    ) u_scancode_fifo (
        .CLOCK_50 (CLOCK_50),
        .rst_n_i  (rst_n_i),
        .push_i   (scancode_valid_i),
        .item_i   (scancode_i),
        .pop_i    (sc_pop),
        .item_o   (sc_head),
        .empty_o  (sc_empty),
        .full_o   (sc_full)
    );

    // The queue's full flag lags our own write by a cycle.
    // A write still in flight therefore counts as no room.
    assign queue_busy = queue_full_i || queue_push_o;

    // Software requests win the slot, the scancode buffer waits.
    assign sw_accept = sw_irq_i && !queue_busy;
    assign sw_drop   = sw_irq_i && queue_busy;
    assign sc_pop    = !sw_irq_i && !sc_empty && !queue_busy;

    // The scancode buffer refuses a strobe when it is full.
    assign key_drop = scancode_valid_i && sc_full;

    always_comb
    begin
        if (sw_irq_i)
        begin
            next_entry.irq_type = sw_irq_type_i;
            next_entry.value    = sw_irq_value_i;
        end
        else
        begin
            // Key interrupts carry the scancode, zero-extended.
            next_entry.irq_type = irq_type_t'(`IRQ_TYPE_KEY);
            next_entry.value    = word_t'(sc_head);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            queue_push_o <= 1'b0;
            overflow_o   <= 1'b0;
        end
        else
        begin
            queue_push_o <= sw_accept || sc_pop;
            overflow_o   <= sw_drop || key_drop;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (sw_accept || sc_pop)
            queue_entry_o <= next_entry;
    end

endmodule

// File: hw/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  CLOCK_50,
    input  logic  rst_n_i,
    input  logic  push_i,
    input  item_t item_i,
    input  logic  pop_i,
    output item_t item_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);

    item_t               mem [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // Pointers wrap at DEPTH, which need not be a power of two.
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        next_ptr = (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_BITS'(DEPTH));

    // Requests against a full or empty buffer have no effect.
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Show-ahead read port.
    assign item_o = mem[rd_ptr];

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            // Push and pop together leave the occupancy as it is.
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (do_push)
            mem[wr_ptr] <= item_i;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the interrupt controller testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal -f filelist.f \
        --top-module tb_irq_controller -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_irq_controller)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

// File: testbench/tb_irq_controller.sv
`timescale 1ns/1ns
`include "irq_settings.svh"

module tb_irq_controller;

    import irq_pkg::*;

    localparam int SEED = 47305;
    // Total of 1 + 12 + 3 + 6 + 19 interrupt strobes over all tests.
    localparam int NUM_ITEMS      = 41;
    localparam int TIMEOUT_CYCLES = NUM_ITEMS * 40 + 400;
    localparam int KEY_CAPACITY   = `IRQ_QUEUE_DEPTH + `IRQ_SCANCODE_DEPTH;

    typedef struct packed {
        word_t     isr_addr;
        word_t     return_addr;
        irq_type_t irq_type;
        word_t     value;
    } expect_t;

    logic      CLOCK_50 = 1'b0;
    logic      rst_n_i;
    scancode_t scancode_i;
    logic      scancode_valid_i;
    logic      sw_irq_i;
    irq_type_t sw_irq_type_i;
    word_t     sw_irq_value_i;
    logic      vector_we_i;
    irq_type_t vector_index_i;
    word_t     vector_addr_i;
    logic      iret_i;
    word_t     ip_i;
    word_t     code_base_i;
    word_t     program_end_i;
    logic      overflow_o;
    logic      dispatch_o;
    word_t     isr_addr_o;
    word_t     return_addr_o;
    irq_type_t irq_type_o;
    word_t     irq_value_o;
    logic      in_service_o;

    // Model of the vector table and of every accepted, not yet dispatched interrupt.
    word_t      model_vectors [`IRQ_NUM_VECTORS];
    irq_entry_t model_q [$];
    int         mismatch_count = 0;
    int         other_errors   = 0;
    logic       service_open   = 1'b0;

    irq_controller u_irq_controller (
        .CLOCK_50         (CLOCK_50),
        .rst_n_i          (rst_n_i),
        .scancode_i       (scancode_i),
        .scancode_valid_i (scancode_valid_i),
        .sw_irq_i         (sw_irq_i),
        .sw_irq_type_i    (sw_irq_type_i),
        .sw_irq_value_i   (sw_irq_value_i),
        .vector_we_i      (vector_we_i),
        .vector_index_i   (vector_index_i),
        .vector_addr_i    (vector_addr_i),
        .iret_i           (iret_i),
        .ip_i             (ip_i),
        .code_base_i      (code_base_i),
        .program_end_i    (program_end_i),
        .overflow_o       (overflow_o),
        .dispatch_o       (dispatch_o),
        .isr_addr_o       (isr_addr_o),
        .return_addr_o    (return_addr_o),
        .irq_type_o       (irq_type_o),
        .irq_value_o      (irq_value_o),
        .in_service_o     (in_service_o)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_type(input string what, input irq_type_t got, input irq_type_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // Service address from the vector table, return address by the program-end rule.
    function automatic expect_t expected_dispatch(input irq_entry_t entry);
        expect_t exp;
        word_t   next_ip;
        next_ip         = ip_i + word_t'(`IRQ_INSTR_BYTES);
        exp.isr_addr    = code_base_i + model_vectors[entry.irq_type];
        exp.return_addr = (next_ip >= program_end_i) ? ip_i : next_ip;
        exp.irq_type    = entry.irq_type;
        exp.value       = entry.value;
        return exp;
    endfunction

    // Compares every dispatch with the oldest accepted interrupt.
    always @(negedge CLOCK_50)
    begin
        irq_entry_t entry;
        expect_t    exp;
        if (rst_n_i && dispatch_o)
        begin
            check_flag("second dispatch while in service", service_open, 1'b0);
            check_flag("in_service_o at dispatch", in_service_o, 1'b1);
            if (model_q.size() == 0)
            begin
                $display("Error at %0t ns: dispatch with no pending interrupt", $time);
                other_errors++;
            end
            else
            begin
                entry = model_q.pop_front();
                exp   = expected_dispatch(entry);
                check_word("isr_addr_o", isr_addr_o, exp.isr_addr);
                check_word("return_addr_o", return_addr_o, exp.return_addr);
                check_type("irq_type_o", irq_type_o, exp.irq_type);
                check_word("irq_value_o", irq_value_o, exp.value);
            end
            service_open = 1'b1;
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge CLOCK_50);
    endtask

    task automatic write_vector(input irq_type_t index, input word_t addr);
        @(posedge CLOCK_50);
        #2;
        vector_we_i    = 1'b1;
        vector_index_i = index;
        vector_addr_i  = addr;
        model_vectors[index] = addr;
        @(posedge CLOCK_50);
        #2;
        vector_we_i = 1'b0;
    endtask

    task automatic set_levels(input word_t ip, input word_t base, input word_t prog_end);
        @(posedge CLOCK_50);
        #2;
        ip_i          = ip;
        code_base_i   = base;
        program_end_i = prog_end;
    endtask

    // A software request fits only while the interrupt queue has room.
    task automatic send_sw(input irq_type_t irq_type, input word_t value);
        irq_entry_t entry;
        logic       drop;
        @(posedge CLOCK_50);
        #2;
        drop           = (model_q.size() >= `IRQ_QUEUE_DEPTH);
        entry.irq_type = irq_type;
        entry.value    = value;
        sw_irq_i       = 1'b1;
        sw_irq_type_i  = irq_type;
        sw_irq_value_i = value;
        if (!drop)
            model_q.push_back(entry);
        @(posedge CLOCK_50);
        #2;
        sw_irq_i = 1'b0;
        @(negedge CLOCK_50);
        check_flag("overflow_o after software strobe", overflow_o, drop);
    endtask

    // Keys may also wait in the scancode buffer.
    task automatic send_key(input scancode_t code);
        irq_entry_t entry;
        logic       drop;
        @(posedge CLOCK_50);
        #2;
        drop             = (model_q.size() >= KEY_CAPACITY);
        entry.irq_type   = irq_type_t'(`IRQ_TYPE_KEY);
        entry.value      = word_t'(code);
        scancode_i       = code;
        scancode_valid_i = 1'b1;
        if (!drop)
            model_q.push_back(entry);
        @(posedge CLOCK_50);
        #2;
        scancode_valid_i = 1'b0;
        @(negedge CLOCK_50);
        check_flag("overflow_o after scancode strobe", overflow_o, drop);
    endtask

    // Waits for the running routine, then returns from it.
    task automatic service_one();
        while (!service_open)
            @(posedge CLOCK_50);
        @(posedge CLOCK_50);
        #2;
        iret_i       = 1'b1;
        service_open = 1'b0;
        @(posedge CLOCK_50);
        #2;
        iret_i = 1'b0;
    endtask

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge CLOCK_50);
        $display("Timeout: simulation still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        void'($urandom(SEED));
        rst_n_i          = 1'b0;
        scancode_i       = '0;
        scancode_valid_i = 1'b0;
        sw_irq_i         = 1'b0;
        sw_irq_type_i    = '0;
        sw_irq_value_i   = '0;
        vector_we_i      = 1'b0;
        vector_index_i   = '0;
        vector_addr_i    = '0;
        iret_i           = 1'b0;
        ip_i             = 32'h0000_1000;
        code_base_i      = 32'h0001_0000;
        program_end_i    = 32'h0000_8000;
        for (int i = 0; i < `IRQ_NUM_VECTORS; i++)
            model_vectors[i] = '0;
        repeat (5) @(posedge CLOCK_50);
        #2;
        rst_n_i = 1'b1;

        // Quiet after reset; an unprogrammed vector lands on the code base.
        repeat (10)
        begin
            @(negedge CLOCK_50);
            check_flag("dispatch_o while idle", dispatch_o, 1'b0);
            check_flag("in_service_o while idle", in_service_o, 1'b0);
        end
        send_sw(irq_type_t'(5), 32'h0000_1234);
        service_one();

        // Random key bursts with programmed vectors.
        for (int i = 0; i < `IRQ_NUM_VECTORS; i++)
            write_vector(irq_type_t'(i), word_t'($urandom_range(32'h0000_fff0, 0)));
        repeat (3)
        begin
            repeat (4) send_key(scancode_t'($urandom_range(255, 0)));
            repeat (4) service_one();
        end

        // Return address far from the program end and right at it.
        set_levels(32'h0000_2000, 32'h0040_0000, 32'h0000_8000);
        send_sw(irq_type_t'(2), 32'h0000_0031);
        service_one();
        set_levels(32'h0000_7ffb, 32'h0040_0000, 32'h0000_8000);
        send_sw(irq_type_t'(3), 32'h0000_0032);
        service_one();
        set_levels(32'h0000_7ff7, 32'h0040_0000, 32'h0000_8000);
        send_sw(irq_type_t'(4), 32'h0000_0033);
        service_one();

        // Mixed requests stay pending behind the routine in service.
        set_levels(32'h0000_3000, 32'h0002_0000, 32'h0000_9000);
        send_sw(irq_type_t'(1), 32'hcafe_0001);
        idle(3);
        send_key(8'h1c);
        idle(3);
        send_sw(irq_type_t'(6), 32'hcafe_0002);
        idle(3);
        send_key(8'h32);
        idle(3);
        send_key(8'hf0);
        idle(3);
        send_sw(irq_type_t'(7), 32'hcafe_0003);
        idle(30);
        @(negedge CLOCK_50);
        check_flag("in_service_o held without iret", in_service_o, 1'b1);
        repeat (6) service_one();

        // Flood while in service until both buffers overflow.
        send_sw(irq_type_t'(4), 32'h0000_beef);
        while (!service_open)
            @(posedge CLOCK_50);
        repeat (17)
        begin
            send_key(scancode_t'($urandom_range(255, 0)));
            idle(3);
        end
        send_sw(irq_type_t'(2), 32'hdead_0005);
        repeat (1 + KEY_CAPACITY) service_one();

        idle(10);
        @(negedge CLOCK_50);
        check_flag("in_service_o after the last return", in_service_o, 1'b0);
        if (model_q.size() != 0)
        begin
            $display("Error: %0d accepted interrupts were never dispatched", model_q.size());
            other_errors++;
        end
        $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
